// File: Bender.yml
package:
  name: cache_traffic_gen

sources:
  - source/cache_pkg.sv
  - source/request_issuer.sv
  - source/read_checker.sv
  - source/test_sequencer.sv
  - source/cache_traffic_gen.sv
  - target: test
    files:
      - test/tb_cache_model.sv
      - test/tb_cache_traffic_gen.sv

// File: files.f
source/cache_pkg.sv
source/request_issuer.sv
source/read_checker.sv
source/test_sequencer.sv
source/cache_traffic_gen.sv
test/tb_cache_model.sv
test/tb_cache_traffic_gen.sv

// File: source/cache_pkg.sv
package cache_pkg;

    // cpu address and block geometry
    localparam int ADDR_WIDTH        = 32;
    localparam int BLOCK_BITS        = 128;
    localparam int BLOCK_OFFSET_BITS = 4;
    localparam int MASK_BITS         = BLOCK_BITS / 8;
    localparam int WORDS_PER_BLOCK   = BLOCK_BITS / 32;

    // packet side fields
    localparam int PORT_ID_WIDTH = 4;
    localparam int TYPE_WIDTH    = 2;

    // port numbers stamped on the two request ways
    localparam logic [PORT_ID_WIDTH-1:0] WRITE_PORT_ID = 4'd0;
    localparam logic [PORT_ID_WIDTH-1:0] READ_PORT_ID  = 4'd1;

    // plain request, no special packet type
    localparam logic [TYPE_WIDTH-1:0] REQ_TYPE = 2'b00;

    // writes always cover the whole block
    localparam logic [MASK_BITS-1:0] WRITE_MASK = {MASK_BITS{1'b1}};

    // one unified cache packet, msb first
    typedef struct packed
    {
        logic [ADDR_WIDTH-1:0]    addr;
        logic [BLOCK_BITS-1:0]    data;
        logic [MASK_BITS-1:0]     byte_mask;
        logic [TYPE_WIDTH-1:0]    packet_type;
        logic [PORT_ID_WIDTH-1:0] port_id;
        logic                     valid;
        logic                     is_write;
        logic                     cacheable;
    } cache_packet_t;

    // sequencer phases
    typedef enum logic [2:0]
    {
        PHASE_IDLE,
        PHASE_WRITING,
        PHASE_READING,
        PHASE_FINISHED,
        PHASE_FAILED
    } phase_t;

    // block i carries i in every 32-bit word
    function automatic logic [BLOCK_BITS-1:0] block_pattern(input logic [31:0] index);
        block_pattern = {WORDS_PER_BLOCK{index}};
    endfunction

    // line address of request i
    function automatic logic [ADDR_WIDTH-1:0] line_addr
    (
        input logic [ADDR_WIDTH-1:0] base,
        input logic [31:0]           index
    );
        line_addr = base + (index << BLOCK_OFFSET_BITS);
    endfunction

endpackage

// File: source/cache_traffic_gen.sv
`timescale 1ns/10ps

module cache_traffic_gen
#(
    parameter int                               num_request    = 16,
    parameter logic [cache_pkg::ADDR_WIDTH-1:0] base_addr      = 32'h1000,
    parameter int                               timeout_cycles = 1000
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    output cache_pkg::cache_packet_t write_req,
    input  logic                    write_ack,
    output cache_pkg::cache_packet_t read_req,
    input  logic                    read_ack,
    input  cache_pkg::cache_packet_t return_pkt,
    output logic                    return_ack,
    output logic                    done,
    output logic                    error
);

    logic write_start;
    logic read_start;
    logic write_finished;
    logic read_issued;
    logic all_checked;
    logic write_timeout;
    logic read_timeout;
    logic check_timeout;
    logic mismatch;

    test_sequencer sequencer
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_start    (write_start),
        .read_start     (read_start),
        .write_finished (write_finished),
        .read_issued    (read_issued),
        .all_checked    (all_checked),
        .write_timeout  (write_timeout),
        .read_timeout   (read_timeout),
        .check_timeout  (check_timeout),
        .mismatch       (mismatch),
        .done           (done),
        .error          (error)
    );

    request_issuer
    #(
        .is_write       (1'b1),
        .port_id        (cache_pkg::WRITE_PORT_ID),
        .num_request    (num_request),
        .base_addr      (base_addr),
        .timeout_cycles (timeout_cycles)
    )
    write_way
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .start     (write_start),
        .ack       (write_ack),
        .req       (write_req),
        .finished  (write_finished),
        .timed_out (write_timeout)
    );

    request_issuer
    #(
        .is_write       (1'b0),
        .port_id        (cache_pkg::READ_PORT_ID),
        .num_request    (num_request),
        .base_addr      (base_addr),
        .timeout_cycles (timeout_cycles)
    )
    read_way
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .start     (read_start),
        .ack       (read_ack),
        .req       (read_req),
        .finished  (read_issued),
        .timed_out (read_timeout)
    );

    // checker runs for the whole read phase
    read_checker
    #(
        .num_request    (num_request),
        .timeout_cycles (timeout_cycles)
    )
    return_check
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .enable      (read_start),
        .return_pkt  (return_pkt),
        .return_ack  (return_ack),
        .all_checked (all_checked),
        .mismatch    (mismatch),
        .timed_out   (check_timeout)
    );

endmodule

// File: source/read_checker.sv
`timescale 1ns/10ps

module read_checker
#(
    parameter int num_request    = 16,
    parameter int timeout_cycles = 1000
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  logic                    enable,
    input  cache_pkg::cache_packet_t return_pkt,
    output logic                    return_ack,
    output logic                    all_checked,
    output logic                    mismatch,
    output logic                    timed_out
);

    localparam int COUNT_WIDTH = $clog2(num_request + 1);
    localparam int WAIT_WIDTH  = $clog2(timeout_cycles + 1);

    localparam logic [COUNT_WIDTH-1:0] LAST_INDEX = COUNT_WIDTH'(num_request - 1);
    localparam logic [WAIT_WIDTH-1:0]  WAIT_LIMIT = WAIT_WIDTH'(timeout_cycles);

    logic [COUNT_WIDTH-1:0]           count;
    logic [WAIT_WIDTH-1:0]            wait_count;
    logic [cache_pkg::BLOCK_BITS-1:0] expected;
    logic                             active;
    logic                             accept;
    logic                             release_ack;

    assign expected = cache_pkg::block_pattern({{(32 - COUNT_WIDTH){1'b0}}, count});

    // still expecting returns and nothing has gone wrong
    assign active = enable && !all_checked && !mismatch && !timed_out;

    // four-phase edges
    assign accept      = active && !return_ack && return_pkt.valid;
    assign release_ack = return_ack && !return_pkt.valid;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            return_ack  <= 1'b0;
            count       <= '0;
            wait_count  <= '0;
            all_checked <= 1'b0;
            mismatch    <= 1'b0;
            timed_out   <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                // compare on the cycle ack rises
                return_ack <= 1'b1;
                count      <= count + 1'b1;
                if (return_pkt.data != expected)
                begin
                    mismatch <= 1'b1;
                end
                if (count == LAST_INDEX)
                begin
                    all_checked <= 1'b1;
                end
            end
            else if (release_ack)
            begin
                return_ack <= 1'b0;
            end

            // any handshake step restarts the wait
            if (accept || release_ack)
            begin
                wait_count <= '0;
            end
            else if (active)
            begin
                if (wait_count == WAIT_LIMIT)
                begin
                    timed_out <= 1'b1;
                end
                else
                begin
                    wait_count <= wait_count + 1'b1;
                end
            end
        end
    end

    // ack may only answer a return that was already valid
    assert property (@(posedge clk_in) disable iff (reset_in)
        $rose(return_ack) |-> $past(return_pkt.valid))
    else
        $error("return_ack rose without a valid return");

endmodule

// File: source/request_issuer.sv
`timescale 1ns/10ps

module request_issuer
#(
    parameter bit                                  is_write       = 1'b1,
    parameter logic [cache_pkg::PORT_ID_WIDTH-1:0] port_id        = cache_pkg::WRITE_PORT_ID,
    parameter int                                  num_request    = 16,
    parameter logic [cache_pkg::ADDR_WIDTH-1:0]    base_addr      = 32'h1000,
    parameter int                                  timeout_cycles = 1000
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  logic                    start,
    input  logic                    ack,
    output cache_pkg::cache_packet_t req,
    output logic                    finished,
    output logic                    timed_out
);

    localparam int COUNT_WIDTH = $clog2(num_request + 1);
    localparam int WAIT_WIDTH  = $clog2(timeout_cycles + 1);

    localparam logic [COUNT_WIDTH-1:0] LAST_INDEX = COUNT_WIDTH'(num_request - 1);
    localparam logic [WAIT_WIDTH-1:0]  WAIT_LIMIT = WAIT_WIDTH'(timeout_cycles);

    logic                   valid_q;
    logic [COUNT_WIDTH-1:0] count;
    logic [WAIT_WIDTH-1:0]  wait_count;
    logic [31:0]            index;

    assign index = {{(32 - COUNT_WIDTH){1'b0}}, count};

    // packet follows the counter, which only moves together with valid falling
    always_comb
    begin
        req             = '0;
        req.addr        = cache_pkg::line_addr(base_addr, index);
        req.packet_type = cache_pkg::REQ_TYPE;
        req.port_id     = port_id;
        req.valid       = valid_q;
        req.is_write    = is_write;
        req.cacheable   = 1'b1;
        if (is_write)
        begin
            req.data      = cache_pkg::block_pattern(index);
            req.byte_mask = cache_pkg::WRITE_MASK;
        end
    end

    // valid/ack handshake with a per-request wait counter
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            valid_q    <= 1'b0;
            count      <= '0;
            wait_count <= '0;
            finished   <= 1'b0;
            timed_out  <= 1'b0;
        end
        else if (!timed_out)
        begin
            if (valid_q)
            begin
                if (ack)
                begin
                    // accepted, drop valid for at least one cycle
                    valid_q    <= 1'b0;
                    count      <= count + 1'b1;
                    wait_count <= '0;
                    if (count == LAST_INDEX)
                    begin
                        finished <= 1'b1;
                    end
                end
                else if (wait_count == WAIT_LIMIT)
                begin
                    timed_out <= 1'b1;
                end
                else
                begin
                    wait_count <= wait_count + 1'b1;
                end
            end
            // new requests only while the way is enabled
            else if (start && !finished)
            begin
                valid_q <= 1'b1;
            end
        end
    end

    // back-pressure must not disturb the presented packet
    assert property (@(posedge clk_in) disable iff (reset_in)
        (req.valid && !ack) |=> $stable(req))
    else
        $error("request changed while waiting for ack");

endmodule

// File: source/test_sequencer.sv
`timescale 1ns/10ps

module test_sequencer
(
    input  logic clk_in,
    input  logic reset_in,
    output logic write_start,
    output logic read_start,
    input  logic write_finished,
    input  logic read_issued,
    input  logic all_checked,
    input  logic write_timeout,
    input  logic read_timeout,
    input  logic check_timeout,
    input  logic mismatch,
    output logic done,
    output logic error
);

    cache_pkg::phase_t phase;
    logic              any_error;

    assign any_error = write_timeout || read_timeout || check_timeout || mismatch;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            phase <= cache_pkg::PHASE_IDLE;
        end
        else
        begin
            case (phase)
                cache_pkg::PHASE_IDLE:
                begin
                    phase <= cache_pkg::PHASE_WRITING;
                end

                cache_pkg::PHASE_WRITING:
                begin
                    if (any_error)
                    begin
                        phase <= cache_pkg::PHASE_FAILED;
                    end
                    else if (write_finished)
                    begin
                        phase <= cache_pkg::PHASE_READING;
                    end
                end

                cache_pkg::PHASE_READING:
                begin
                    // reads issued and every return checked
                    if (any_error)
                    begin
                        phase <= cache_pkg::PHASE_FAILED;
                    end
                    else if (read_issued && all_checked)
                    begin
                        phase <= cache_pkg::PHASE_FINISHED;
                    end
                end

                // finished and failed hold until reset
                default:
                begin
                    phase <= phase;
                end
            endcase
        end
    end

    assign write_start = (phase == cache_pkg::PHASE_WRITING);
    assign read_start  = (phase == cache_pkg::PHASE_READING);
    assign done        = (phase == cache_pkg::PHASE_FINISHED);
    assign error       = (phase == cache_pkg::PHASE_FAILED);

    assert property (@(posedge clk_in) disable iff (reset_in) !(done && error))
    else
        $error("done and error high together");

endmodule

// File: test/tb_cache_model.sv
`timescale 1ns/10ps

module tb_cache_model
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  cache_pkg::cache_packet_t write_req,
    output logic                     write_ack,
    input  cache_pkg::cache_packet_t read_req,
    output logic                     read_ack,
    output cache_pkg::cache_packet_t return_pkt,
    input  logic                     return_ack,
    input  int                       max_delay,
    input  int                       corrupt_index,
    input  int                       withhold_index
);

    // written blocks by line address
    logic [cache_pkg::BLOCK_BITS-1:0] mem [logic [cache_pkg::ADDR_WIDTH-1:0]];
    // reads accepted but not yet returned
    logic [cache_pkg::ADDR_WIDTH-1:0] pending [$];
    int write_count;
    int return_count;
    int write_wait;
    int read_wait;
    int return_wait;
    bit releasing;

    function automatic int draw_delay();
        return (max_delay > 0) ? int'($urandom % (max_delay + 1)) : 0;
    endfunction

    task automatic clear_state();
        write_ack    = 1'b0;
        read_ack     = 1'b0;
        return_pkt   = '0;
        write_count  = 0;
        return_count = 0;
        write_wait   = 0;
        read_wait    = 0;
        return_wait  = 0;
        releasing    = 1'b0;
        pending.delete();
        mem.delete();
    endtask

    // one process so that every delay comes from the same seeded stream
    initial
    begin
        logic [cache_pkg::ADDR_WIDTH-1:0] addr;
        void'($urandom(32'ha5ab));
        clear_state();
        forever
        begin
            @(negedge clk_in);
            if (reset_in)
            begin
                clear_state();
            end
            else
            begin
                // write way, ack drops once valid is gone
                if (write_ack)
                begin
                    write_ack = write_req.valid;
                end
                else if (write_req.valid && write_count != withhold_index)
                begin
                    if (write_wait > 0)
                    begin
                        write_wait--;
                    end
                    else
                    begin
                        mem[write_req.addr] = write_req.data;
                        write_ack = 1'b1;
                        write_count++;
                        write_wait = draw_delay();
                    end
                end

                // read way queues the address for a later return
                if (read_ack)
                begin
                    read_ack = read_req.valid;
                end
                else if (read_req.valid)
                begin
                    if (read_wait > 0)
                    begin
                        read_wait--;
                    end
                    else
                    begin
                        pending.push_back(read_req.addr);
                        read_ack  = 1'b1;
                        read_wait = draw_delay();
                    end
                end

                // four-phase return
                if (return_pkt.valid)
                begin
                    if (return_ack)
                    begin
                        return_pkt.valid = 1'b0;
                        releasing        = 1'b1;
                    end
                end
                else if (releasing)
                begin
                    if (!return_ack)
                    begin
                        releasing   = 1'b0;
                        return_wait = draw_delay();
                    end
                end
                else if (pending.size() > 0)
                begin
                    if (return_wait > 0)
                    begin
                        return_wait--;
                    end
                    else
                    begin
                        addr                 = pending.pop_front();
                        return_pkt           = '0;
                        return_pkt.addr      = addr;
                        return_pkt.data      = mem.exists(addr) ? mem[addr] : '0;
                        return_pkt.port_id   = cache_pkg::READ_PORT_ID;
                        return_pkt.valid     = 1'b1;
                        return_pkt.cacheable = 1'b1;
                        // flip one bit of the chosen block
                        if (return_count == corrupt_index)
                        begin
                            return_pkt.data[0] = ~return_pkt.data[0];
                        end
                        return_count++;
                    end
                end
            end
        end
    end

endmodule

// File: test/tb_cache_traffic_gen.sv
`timescale 1ns/10ps

module tb_cache_traffic_gen;

    localparam int                               NUM_REQUEST    = 16;
    localparam logic [cache_pkg::ADDR_WIDTH-1:0] BASE_ADDR      = 32'h1000;
    localparam int                               TIMEOUT_CYCLES = 64;
    localparam int                               VERDICT_LIMIT  = 4000;

    logic                     clk_in;
    logic                     reset_in;
    cache_pkg::cache_packet_t write_req;
    cache_pkg::cache_packet_t read_req;
    cache_pkg::cache_packet_t return_pkt;
    logic                     write_ack;
    logic                     read_ack;
    logic                     return_ack;
    logic                     done;
    logic                     error;
    int                       max_delay;
    int                       corrupt_index;
    int                       withhold_index;
    int                       error_count;
    int                       check_count;
    int                       write_seen;
    int                       read_seen;

    cache_traffic_gen
    #(
        .num_request    (NUM_REQUEST),
        .base_addr      (BASE_ADDR),
        .timeout_cycles (TIMEOUT_CYCLES)
    )
    DUT
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .write_req  (write_req),
        .write_ack  (write_ack),
        .read_req   (read_req),
        .read_ack   (read_ack),
        .return_pkt (return_pkt),
        .return_ack (return_ack),
        .done       (done),
        .error      (error)
    );

    tb_cache_model cache
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_req      (write_req),
        .write_ack      (write_ack),
        .read_req       (read_req),
        .read_ack       (read_ack),
        .return_pkt     (return_pkt),
        .return_ack     (return_ack),
        .max_delay      (max_delay),
        .corrupt_index  (corrupt_index),
        .withhold_index (withhold_index)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // request i: line base + 16*i, writes carry i in each 32-bit word
    function automatic cache_pkg::cache_packet_t expected_packet(input int index, input bit is_write);
        cache_pkg::cache_packet_t pkt;
        logic [31:0]              word;
        word            = index;
        pkt             = '0;
        pkt.addr        = BASE_ADDR + word * 16;
        pkt.port_id     = is_write ? cache_pkg::WRITE_PORT_ID : cache_pkg::READ_PORT_ID;
        pkt.valid       = 1'b1;
        pkt.is_write    = is_write;
        pkt.cacheable   = 1'b1;
        if (is_write)
        begin
            pkt.data      = {4{word}};
            pkt.byte_mask = '1;
        end
        return pkt;
    endfunction

    task automatic check_packet(input string name, input cache_pkg::cache_packet_t actual,
                                input cache_pkg::cache_packet_t expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_total(input string name, input int actual, input int expected);
        check_count++;
        if (actual != expected)
        begin
            $display("error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // every accepted request against the reference, read order against the write way
    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_seen = 0;
            read_seen  = 0;
        end
        else
        begin
            if (read_req.valid && write_seen < NUM_REQUEST)
            begin
                $display("error at %0t: read valid before the last write was acked", $time);
                error_count++;
            end
            if (write_req.valid && write_ack)
            begin
                check_packet("write_req", write_req, expected_packet(write_seen, 1'b1));
                write_seen++;
            end
            if (read_req.valid && read_ack)
            begin
                check_packet("read_req", read_req, expected_packet(read_seen, 1'b0));
                read_seen++;
            end
        end
    end

    task automatic run_scenario(input string name, input int delay, input int corrupt,
                                input int withhold);
        bit expect_pass;
        int cycles;
        expect_pass = (corrupt < 0) && (withhold < 0);
        @(negedge clk_in);
        reset_in       = 1'b1;
        max_delay      = delay;
        corrupt_index  = corrupt;
        withhold_index = withhold;
        repeat (2) @(negedge clk_in);
        reset_in = 1'b0;
        // quiet straight out of reset
        check_flag("done", done, 1'b0);
        check_flag("error", error, 1'b0);
        check_flag("write_req.valid", write_req.valid, 1'b0);
        check_flag("read_req.valid", read_req.valid, 1'b0);
        check_flag("return_ack", return_ack, 1'b0);
        cycles = 0;
        while (!done && !error && cycles < VERDICT_LIMIT)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!done && !error)
        begin
            $display("%s: neither done nor error within %0d cycles", name, VERDICT_LIMIT);
            error_count++;
        end
        // verdict has to stay put
        repeat (4) @(negedge clk_in);
        check_flag("done", done, expect_pass);
        check_flag("error", error, !expect_pass);
        check_total("write requests", write_seen, (withhold < 0) ? NUM_REQUEST : withhold);
        if (expect_pass)
        begin
            check_total("read requests", read_seen, NUM_REQUEST);
        end
        else if (withhold >= 0)
        begin
            check_total("read requests", read_seen, 0);
        end
    endtask

    initial
    begin
        reset_in       = 1'b1;
        max_delay      = 0;
        corrupt_index  = -1;
        withhold_index = -1;
        error_count    = 0;
        check_count    = 0;
        run_scenario("back to back", 0, -1, -1);
        run_scenario("random delays", 6, -1, -1);
        run_scenario("corrupted block", 3, 5, -1);
        run_scenario("withheld write ack", 2, -1, 3);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
